/* hdl/lab_settings.svh */
`ifndef LAB_SETTINGS_SVH
`define LAB_SETTINGS_SVH

// width of the random shift register
`define LFSR_WIDTH 8

// loaded when the register has fallen into the all-zero state
`define LFSR_RESTART 1

`endif

/* hdl/lab_pkg.sv */
package lab_pkg;

    // experiment currently shown on the board
    typedef enum logic [1:0] {
        MODE_ALU    = 2'd0,
        MODE_SHIFT  = 2'd1,
        MODE_ENCODE = 2'd2,
        MODE_RANDOM = 2'd3
    } lab_mode_e;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_NOT = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5,
        OP_SLT = 3'd6,
        OP_EQ  = 3'd7
    } alu_op_e;

    typedef struct packed {
        logic [3:0] value;
        logic       zero;
        logic       overflow;
        logic       carry;
    } alu_result_t;

    // field order matches sw[15:13], sw[12], sw[11]
    typedef struct packed {
        logic [2:0] amount;
        logic       left;
        logic       arith;
    } shift_ctrl_t;

    typedef struct packed {
        logic [2:0] index;
        logic       valid;
    } enc_result_t;

endpackage

/* hdl/alu.sv */
module alu import lab_pkg::*; (
    input  logic [3:0]  a,
    input  logic [3:0]  b,
    input  alu_op_e     op,
    output alu_result_t result
);

    logic [4:0] sum;
    logic [4:0] diff;
    logic       add_ovf;
    logic       sub_ovf;
    logic       less;

    // extra top bit holds carry out, or borrow for sub
    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    // overflow from operand signs against result sign
    assign add_ovf = (a[3] == b[3]) && (sum[3] != a[3]);
    assign sub_ovf = (a[3] != b[3]) && (diff[3] != a[3]);

    assign less = $signed(a) < $signed(b);

    always_comb begin
        result = '0;
        case (op)
            OP_ADD: begin
                result.value    = sum[3:0];
                result.carry    = sum[4];
                result.overflow = add_ovf;
            end
            OP_SUB: begin
                result.value    = diff[3:0];
                result.carry    = diff[4];
                result.overflow = sub_ovf;
            end
            OP_NOT: begin
                result.value = ~a;
            end
            OP_AND: begin
                result.value = a & b;
            end
            OP_OR: begin
                result.value = a | b;
            end
            OP_XOR: begin
                result.value = a ^ b;
            end
            OP_SLT: begin
                result.value = {3'b000, less};
            end
            OP_EQ: begin
                result.value = {3'b000, (a == b)};
            end
            default: begin
                result.value = 4'd0;
            end
        endcase
        // zero flag applies to every opcode
        result.zero = (result.value == 4'd0);
    end

endmodule

/* hdl/barrel_shifter.sv */
module barrel_shifter import lab_pkg::*; (
    input  logic [7:0]  din,
    input  shift_ctrl_t ctrl,
    output logic [7:0]  dout
);

    logic       fill;
    logic [7:0] stage0;
    logic [7:0] stage1;

    // sign copy for arithmetic right shifts, stays valid through all stages
    assign fill = ctrl.arith & din[7];

    // by 1
    assign stage0 = !ctrl.amount[0] ? din :
                    ctrl.left       ? {din[6:0], 1'b0} :
                                      {fill, din[7:1]};

    // by 2
    assign stage1 = !ctrl.amount[1] ? stage0 :
                    ctrl.left       ? {stage0[5:0], 2'b00} :
                                      {{2{fill}}, stage0[7:2]};

    // by 4
    assign dout = !ctrl.amount[2] ? stage1 :
                  ctrl.left       ? {stage1[3:0], 4'b0000} :
                                    {{4{fill}}, stage1[7:4]};

endmodule

/* hdl/priority_encoder.sv */
module priority_encoder import lab_pkg::*; (
    input  logic [7:0]  din,
    input  logic        en,
    output enc_result_t result
);

    always_comb begin
        result = '0;
        if (en) begin
            // later hits win, so the highest set bit ends up reported
            for (int i = 0; i < 8; i++) begin
                if (din[i]) begin
                    result.index = 3'(i);
                    result.valid = 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/lfsr_gen.sv */
`include "lab_settings.svh"

module lfsr_gen (
    input  logic                   btn,
    input  logic                   rst_n,
    input  logic                   step,
    output logic [`LFSR_WIDTH-1:0] value
);

    logic feedback;

    // taps at bits 4, 3, 2 and 0
    assign feedback = value[4] ^ value[3] ^ value[2] ^ value[0];

    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            value <= '0;
        end else if (step) begin
            if (value == '0) begin
                // stuck state, restart the sequence
                value <= `LFSR_WIDTH'(`LFSR_RESTART);
            end else begin
                value <= {feedback, value[`LFSR_WIDTH-1:1]};
            end
        end
    end

endmodule

/* hdl/seg_hex.sv */
module seg_hex (
    input  logic [3:0] num,
    input  logic       blank,
    output logic [7:0] led
);

    // active-high pattern, bit 0 is segment a
    logic [6:0] seg_on;

    always_comb begin
        case (num)
            4'h0: seg_on = 7'h3f;
            4'h1: seg_on = 7'h06;
            4'h2: seg_on = 7'h5b;
            4'h3: seg_on = 7'h4f;
            4'h4: seg_on = 7'h66;
            4'h5: seg_on = 7'h6d;
            4'h6: seg_on = 7'h7d;
            4'h7: seg_on = 7'h07;
            4'h8: seg_on = 7'h7f;
            4'h9: seg_on = 7'h6f;
            4'ha: seg_on = 7'h77;
            4'hb: seg_on = 7'h7c;
            4'hc: seg_on = 7'h39;
            4'hd: seg_on = 7'h5e;
            4'he: seg_on = 7'h79;
            default: seg_on = 7'h71;
        endcase
    end

    // board segments are active low, decimal point stays dark
    assign led = blank ? 8'hff : {1'b1, ~seg_on};

endmodule

/* hdl/lab_top.sv */
`include "lab_settings.svh"

module lab_top import lab_pkg::*; (
    input  logic        btn,
    input  logic        rst_n,
    input  lab_mode_e   mode,
    input  logic [15:0] sw,
    output logic [15:0] ledr,
    output logic [7:0]  seg0,
    output logic [7:0]  seg1
);

    alu_result_t            alu_res;
    shift_ctrl_t            shift_ctrl;
    logic [7:0]             shift_out;
    enc_result_t            enc_res;
    logic                   rnd_step;
    logic [`LFSR_WIDTH-1:0] rnd_value;

    logic [3:0]             digit0;
    logic [3:0]             digit1;
    logic                   blank0;
    logic                   blank1;

    // amount, direction, arithmetic flag
    assign shift_ctrl = shift_ctrl_t'(sw[15:11]);

    // sequence only advances while it is on display
    assign rnd_step = (mode == MODE_RANDOM);

    alu u_alu (
        .a      (sw[3:0]),
        .b      (sw[7:4]),
        .op     (alu_op_e'(sw[10:8])),
        .result (alu_res)
    );

    barrel_shifter u_shifter (
        .din  (sw[7:0]),
        .ctrl (shift_ctrl),
        .dout (shift_out)
    );

    priority_encoder u_encoder (
        .din    (sw[7:0]),
        .en     (sw[8]),
        .result (enc_res)
    );

    lfsr_gen u_lfsr (
        .btn   (btn),
        .rst_n (rst_n),
        .step  (rnd_step),
        .value (rnd_value)
    );

    always_comb begin
        ledr   = '0;
        digit0 = 4'd0;
        digit1 = 4'd0;
        blank0 = 1'b1;
        blank1 = 1'b1;
        case (mode)
            MODE_ALU: begin
                ledr[3:0] = alu_res.value;
                ledr[4]   = alu_res.zero;
                ledr[5]   = alu_res.overflow;
                ledr[6]   = alu_res.carry;
                digit0    = alu_res.value;
                blank0    = 1'b0;
            end
            MODE_SHIFT: begin
                ledr[7:0] = shift_out;
                digit0    = shift_out[3:0];
                digit1    = shift_out[7:4];
                blank0    = 1'b0;
                blank1    = 1'b0;
            end
            MODE_ENCODE: begin
                ledr[2:0] = enc_res.index;
                ledr[4]   = enc_res.valid;
                digit0    = {1'b0, enc_res.index};
                blank0    = 1'b0;
            end
            default: begin
                ledr   = {{(16-`LFSR_WIDTH){1'b0}}, rnd_value};
                digit0 = rnd_value[3:0];
                digit1 = rnd_value[7:4];
                blank0 = 1'b0;
                blank1 = 1'b0;
            end
        endcase
    end

    seg_hex u_seg0 (
        .num   (digit0),
        .blank (blank0),
        .led   (seg0)
    );

    seg_hex u_seg1 (
        .num   (digit1),
        .blank (blank1),
        .led   (seg1)
    );

endmodule

/* sim/lab_assert.sv */
`include "lab_settings.svh"

module lab_assert import lab_pkg::*; (
    input logic                   btn,
    input logic                   rst_n,
    input lab_mode_e              mode,
    input logic [15:0]            ledr,
    input logic                   rnd_step,
    input logic [`LFSR_WIDTH-1:0] rnd_value
);

    timeunit 1ns;
    timeprecision 1ps;

    // register only moves while random mode is selected
    hold_outside_random: assert property (
        @(posedge btn) disable iff (!rst_n)
        (rst_n && mode != MODE_RANDOM) |=> $stable(rnd_value)
    ) else $error("random register changed outside random mode");

    upper_lamps_dark: assert property (
        @(posedge btn) ledr[15:8] == 8'h00
    ) else $error("lamps 15 to 8 are lit");

    // stuck state must reload the restart value on the next step
    zero_restarts: assert property (
        @(posedge btn) disable iff (!rst_n)
        (rst_n && rnd_step && rnd_value == '0) |=> rnd_value == `LFSR_WIDTH'(`LFSR_RESTART)
    ) else $error("all-zero register did not reload the restart value");

endmodule

bind lab_top lab_assert u_lab_assert (
    .btn       (btn),
    .rst_n     (rst_n),
    .mode      (mode),
    .ledr      (ledr),
    .rnd_step  (rnd_step),
    .rnd_value (rnd_value)
);

/* sim/lab_tb.sv */
`include "lab_settings.svh"

module lab_tb import lab_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 5;
    localparam int ALU_COUNT    = 300;
    localparam int SHIFT_COUNT  = 300;
    localparam int ENC_COUNT    = 200;
    localparam int RND_COUNT    = 300;
    localparam int HOLD_ROUNDS  = 6;
    localparam int HOLD_STEPS   = 4;
    localparam int HOLD_MAX     = 12;
    // worst case per hold round and the closing reset sequence
    localparam int HOLD_CYCLES  = HOLD_ROUNDS * (HOLD_STEPS + HOLD_MAX + 2) + 3;
    localparam int MAX_CYCLES   = RESET_CYCLES + ALU_COUNT + SHIFT_COUNT + ENC_COUNT
                                  + RND_COUNT + 1 + HOLD_CYCLES + 50;

    logic        btn;
    logic        rst_n;
    lab_mode_e   mode;
    logic [15:0] sw;
    logic [15:0] ledr;
    logic [7:0]  seg0;
    logic [7:0]  seg1;

    logic [`LFSR_WIDTH-1:0] model_rnd;

    int pass_count;
    int fail_count;
    int test_checks;
    int test_errors;
    int cycle_count;

    lab_top dut0 (
        .btn   (btn),
        .rst_n (rst_n),
        .mode  (mode),
        .sw    (sw),
        .ledr  (ledr),
        .seg0  (seg0),
        .seg1  (seg1)
    );

    initial begin
        btn = 1'b0;
        forever #50 btn = ~btn;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge btn);
            cycle_count++;
            if (cycle_count >= MAX_CYCLES) begin
                $display("Timeout: the run did not end within %0d clock cycles", MAX_CYCLES);
                $display("Simulation finished: FAIL");
                $finish;
            end
        end
    end

    function automatic int to_signed4(logic [3:0] v);
        return v[3] ? int'(v) - 16 : int'(v);
    endfunction

    function automatic alu_result_t alu_model(logic [3:0] a, logic [3:0] b, alu_op_e op);
        alu_result_t r;
        int          res;
        int          sres;
        r = '0;
        case (op)
            OP_ADD: begin
                res        = int'(a) + int'(b);
                sres       = to_signed4(a) + to_signed4(b);
                r.value    = 4'(res);
                r.carry    = (res > 15);
                r.overflow = (sres > 7) || (sres < -8);
            end
            OP_SUB: begin
                res        = int'(a) - int'(b);
                sres       = to_signed4(a) - to_signed4(b);
                r.value    = 4'(res);
                r.carry    = (res < 0);
                r.overflow = (sres > 7) || (sres < -8);
            end
            OP_NOT: r.value = ~a;
            OP_AND: r.value = a & b;
            OP_OR:  r.value = a | b;
            OP_XOR: r.value = a ^ b;
            OP_SLT: r.value = (to_signed4(a) < to_signed4(b)) ? 4'd1 : 4'd0;
            default: r.value = (a == b) ? 4'd1 : 4'd0;
        endcase
        r.zero = (r.value == 4'd0);
        return r;
    endfunction

    // one place per loop pass
    function automatic logic [7:0] shift_model(logic [7:0] d, shift_ctrl_t c);
        logic [7:0] r;
        r = d;
        for (int i = 0; i < int'(c.amount); i++) begin
            if (c.left) begin
                r = {r[6:0], 1'b0};
            end else begin
                r = {c.arith & d[7], r[7:1]};
            end
        end
        return r;
    endfunction

    function automatic enc_result_t enc_model(logic [7:0] d, logic en);
        enc_result_t r;
        logic        found;
        r = '0;
        found = 1'b0;
        for (int i = 7; i >= 0; i--) begin
            if (en && d[i] && !found) begin
                r.index = 3'(i);
                r.valid = 1'b1;
                found   = 1'b1;
            end
        end
        return r;
    endfunction

    // segments gfedcba lit high before the board inversion
    function automatic logic [7:0] seg_model(logic [3:0] num);
        logic [6:0] lit;
        case (num)
            4'h0: lit = 7'b0111111;
            4'h1: lit = 7'b0000110;
            4'h2: lit = 7'b1011011;
            4'h3: lit = 7'b1001111;
            4'h4: lit = 7'b1100110;
            4'h5: lit = 7'b1101101;
            4'h6: lit = 7'b1111101;
            4'h7: lit = 7'b0000111;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1101111;
            4'ha: lit = 7'b1110111;
            4'hb: lit = 7'b1111100;
            4'hc: lit = 7'b0111001;
            4'hd: lit = 7'b1011110;
            4'he: lit = 7'b1111001;
            default: lit = 7'b1110001;
        endcase
        return {1'b1, ~lit};
    endfunction

    function automatic logic [`LFSR_WIDTH-1:0] lfsr_model(logic [`LFSR_WIDTH-1:0] v);
        if (v == '0) begin
            return `LFSR_WIDTH'(`LFSR_RESTART);
        end
        return {v[4] ^ v[3] ^ v[2] ^ v[0], v[`LFSR_WIDTH-1:1]};
    endfunction

    // steps whenever random mode was selected before the edge
    always @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            model_rnd <= '0;
        end else if (mode == MODE_RANDOM) begin
            model_rnd <= lfsr_model(model_rnd);
        end
    end

    task automatic count_result(input logic ok);
        test_checks++;
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
            test_errors++;
        end
    endtask

    task automatic check_alu(input alu_result_t got, input alu_result_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got value %h z%b v%b c%b, expected value %h z%b v%b c%b",
                     $time, what, got.value, got.zero, got.overflow, got.carry,
                     exp.value, exp.zero, exp.overflow, exp.carry);
        end
        count_result(got === exp);
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
        count_result(got === exp);
    endtask

    task automatic check_enc(input enc_result_t got, input enc_result_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got index %0d valid %b, expected index %0d valid %b",
                     $time, what, got.index, got.valid, exp.index, exp.valid);
        end
        count_result(got === exp);
    endtask

    task automatic check_seg(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s segments %b, expected %b", $time, what, got, exp);
        end
        count_result(got === exp);
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic report_test(input string name);
        $display("test %s done: %0d checks, %0d errors", name, test_checks, test_errors);
    endtask

    task automatic run_alu_test();
        alu_result_t exp;
        alu_result_t got;
        start_test();
        for (int n = 0; n < ALU_COUNT; n++) begin
            @(posedge btn);
            mode <= MODE_ALU;
            sw   <= 16'($urandom());
            @(negedge btn);
            exp          = alu_model(sw[3:0], sw[7:4], alu_op_e'(sw[10:8]));
            got.value    = ledr[3:0];
            got.zero     = ledr[4];
            got.overflow = ledr[5];
            got.carry    = ledr[6];
            check_alu(got, exp, "alu result");
            // lamp 7 and the upper byte are unused here
            check_byte(ledr[7:0] & 8'h80, 8'h00, "alu unused lamp");
            check_byte(ledr[15:8], 8'h00, "alu upper lamps");
            check_seg(seg0, seg_model(exp.value), "alu seg0");
            check_seg(seg1, 8'hff, "alu seg1");
        end
        report_test("alu");
    endtask

    task automatic run_shift_test();
        shift_ctrl_t ctrl;
        logic [7:0]  exp;
        start_test();
        for (int n = 0; n < SHIFT_COUNT; n++) begin
            @(posedge btn);
            mode <= MODE_SHIFT;
            sw   <= 16'($urandom());
            @(negedge btn);
            ctrl.amount = sw[15:13];
            ctrl.left   = sw[12];
            ctrl.arith  = sw[11];
            exp = shift_model(sw[7:0], ctrl);
            check_byte(ledr[7:0], exp, "shifted data");
            check_byte(ledr[15:8], 8'h00, "shift upper lamps");
            check_seg(seg0, seg_model(exp[3:0]), "shift seg0");
            check_seg(seg1, seg_model(exp[7:4]), "shift seg1");
        end
        report_test("shift");
    endtask

    task automatic run_encode_test();
        logic [15:0] stim;
        enc_result_t exp;
        enc_result_t got;
        start_test();
        for (int n = 0; n < ENC_COUNT; n++) begin
            stim = 16'($urandom());
            if (n % 5 == 0) begin
                stim[7:0] = 8'h01 << $urandom_range(0, 7);
            end
            if (n % 7 == 0) begin
                stim[7:0] = 8'h00;
            end
            @(posedge btn);
            mode <= MODE_ENCODE;
            sw   <= stim;
            @(negedge btn);
            exp       = enc_model(stim[7:0], stim[8]);
            got.index = ledr[2:0];
            got.valid = ledr[4];
            check_enc(got, exp, "encoder result");
            // lamps 3 and 7 to 5 stay dark in this mode
            check_byte(ledr[7:0] & 8'he8, 8'h00, "encode unused lamps");
            check_byte(ledr[15:8], 8'h00, "encode upper lamps");
            check_seg(seg0, seg_model({1'b0, exp.index}), "encode seg0");
            check_seg(seg1, 8'hff, "encode seg1");
        end
        report_test("encode");
    endtask

    task automatic run_random_test();
        start_test();
        @(posedge btn);
        mode <= MODE_RANDOM;
        sw   <= 16'($urandom());
        @(negedge btn);
        check_byte(ledr[7:0], 8'h00, "random first read");
        for (int n = 0; n < RND_COUNT; n++) begin
            @(posedge btn);
            sw <= 16'($urandom());
            @(negedge btn);
            check_byte(ledr[7:0], model_rnd, "random step");
            check_byte(ledr[15:8], 8'h00, "random upper lamps");
            check_seg(seg0, seg_model(model_rnd[3:0]), "random seg0");
            check_seg(seg1, seg_model(model_rnd[7:4]), "random seg1");
        end
        report_test("random");
    endtask

    task automatic run_hold_test();
        logic [7:0] held;
        int         wait_cycles;
        start_test();
        for (int r = 0; r < HOLD_ROUNDS; r++) begin
            repeat (HOLD_STEPS) begin
                @(posedge btn);
                mode <= MODE_RANDOM;
                @(negedge btn);
                check_byte(ledr[7:0], model_rnd, "random before hold");
            end
            // the leaving edge still steps the register
            @(posedge btn);
            mode <= lab_mode_e'(2'($urandom_range(0, 2)));
            @(negedge btn);
            held = model_rnd;
            wait_cycles = int'($urandom_range(1, HOLD_MAX));
            repeat (wait_cycles) begin
                @(posedge btn);
                sw <= 16'($urandom());
            end
            @(posedge btn);
            mode <= MODE_RANDOM;
            @(negedge btn);
            check_byte(ledr[7:0], held, "resume after hold");
        end
        @(posedge btn);
        rst_n <= 1'b0;
        @(negedge btn);
        check_byte(ledr[7:0], 8'h00, "mid-run reset");
        @(posedge btn);
        rst_n <= 1'b1;
        @(negedge btn);
        check_byte(ledr[7:0], 8'h00, "reset release");
        @(posedge btn);
        @(negedge btn);
        check_byte(ledr[7:0], 8'(`LFSR_RESTART), "first step after reset");
        check_byte(ledr[7:0], model_rnd, "model after reset");
        report_test("hold and resume");
    endtask

    initial begin
        rst_n      = 1'b0;
        mode       = MODE_ALU;
        sw         = '0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(38927));
        repeat (RESET_CYCLES) @(posedge btn);
        rst_n <= 1'b1;

        run_alu_test();
        run_shift_test();
        run_encode_test();
        run_random_test();
        run_hold_test();

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+hdl
hdl/lab_pkg.sv
hdl/alu.sv
hdl/barrel_shifter.sv
hdl/priority_encoder.sv
hdl/lfsr_gen.sv
hdl/seg_hex.sv
hdl/lab_top.sv
sim/lab_assert.sv
sim/lab_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lab_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_TEXT ?= Simulation finished: FAIL
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
